//--- logic/friet_pkg.sv
// Friet duplex shared definitions: widths, command codes, rotations and round constants
`default_nettype none

package friet_pkg;

    localparam int limb_w = 128;
    localparam int state_w = 512;
    localparam int size_w = 5;
    localparam int rc_w = 5;
    localparam int total_rounds = 24;

    // Bytes in one full input block
    localparam int block_bytes = limb_w / 8;

    typedef logic [limb_w-1:0] limb_t;
    typedef logic [state_w-1:0] state_t;
    typedef logic [size_w-1:0] size_t;
    typedef logic [rc_w-1:0] rc_t;

    typedef enum logic [2:0] {
        oper_init = 3'b000,
        oper_enc = 3'b001,
        oper_dec = 3'b010,
        oper_squeeze = 3'b011,
        oper_direct = 3'b100,
        oper_enc_silent = 3'b101,
        oper_dec_silent = 3'b110,
        oper_reserved = 3'b111
    } oper_t;

    // Constant of the first round
    localparam rc_t master_rc = 5'b01111;

    // Left rotation amounts used by the round
    localparam int rot_mix = 1;
    localparam int rot_and_b = 5;
    localparam int rot_and_c = 18;

    // LFSR step, feedback from bits 4 and 2
    function automatic rc_t rc_step(input rc_t rc);
        return {rc[rc_w-2:0], rc[4] ^ rc[2]};
    endfunction

    // First constant of the batch that finishes the permutation
    function automatic rc_t end_rc(input int unsigned rounds_per_cycle);
        rc_t rc;
        rc = master_rc;
        for (int unsigned i = 0; i < total_rounds - rounds_per_cycle; i++) begin
            rc = rc_step(rc);
        end
        return rc;
    endfunction

endpackage

`default_nettype wire

//--- logic/friet_round.sv
// Friet round: one parity-preserving permutation round on limbs a, b, c and parity d
`timescale 1ns/10ps
`default_nettype none

module friet_round (
    input  friet_pkg::state_t state,
    input  friet_pkg::rc_t    rc_c,
    input  friet_pkg::rc_t    rc_d,
    output friet_pkg::state_t new_state
);

    function automatic friet_pkg::limb_t rotl(input friet_pkg::limb_t x, input int unsigned n);
        return (x << n) | (x >> (friet_pkg::limb_w - n));
    endfunction

    friet_pkg::limb_t a, b, c, d;
    friet_pkg::limb_t a_rot, b_rot, c_rot;
    friet_pkg::limb_t mix_term, nl_term;

    assign {d, c, b, a} = state;

    always_comb begin
        // Constant injection, both constants land in d as well
        c_rot = c ^ friet_pkg::limb_t'(rc_c);
        b_rot = b ^ friet_pkg::limb_t'(rc_d);

        // Limb rotation (a, b, c) -> (c, a, b)
        a_rot = c_rot;
        c_rot = b_rot;
        b_rot = a;

        // Mixing into c
        mix_term = rotl(b_rot, friet_pkg::rot_mix);
        c_rot = c_rot ^ mix_term;

        // Nonlinear step into a
        nl_term = rotl(b_rot, friet_pkg::rot_and_b) & rotl(c_rot, friet_pkg::rot_and_c);
        a_rot = a_rot ^ nl_term;
    end

    // Parity limb tracks every change made to the data limbs
    assign new_state = {
        d ^ friet_pkg::limb_t'(rc_c) ^ friet_pkg::limb_t'(rc_d) ^ mix_term ^ nl_term,
        c_rot, b_rot, a_rot
    };

endmodule

`default_nettype wire

//--- logic/friet_absorb.sv
// Friet absorb: padding, byte masking and encrypt/decrypt injection of one input block
`timescale 1ns/10ps
`default_nettype none

module friet_absorb (
    input  friet_pkg::state_t state,
    input  friet_pkg::limb_t  din,
    input  friet_pkg::size_t  din_size,
    input  logic              din_last,
    input  logic              decrypt,
    input  logic              direct,
    input  logic              squeeze,
    output friet_pkg::state_t absorbed_state,
    output friet_pkg::limb_t  out_data
);

    localparam int lw = friet_pkg::limb_w;
    localparam int pad_w = lw + 2;

    friet_pkg::limb_t a, b, c, d;
    friet_pkg::size_t size_sat;
    friet_pkg::limb_t mask;
    friet_pkg::limb_t din_xor_a;
    friet_pkg::limb_t inject_data;
    friet_pkg::limb_t inj_a, inj_b;
    logic [pad_w-1:0] pad;
    logic pad_bit;

    assign {d, c, b, a} = state;

    // Counts above a full block saturate
    assign size_sat = (din_size > friet_pkg::size_t'(friet_pkg::block_bytes)) ?
                      friet_pkg::size_t'(friet_pkg::block_bytes) : din_size;

    always_comb begin
        for (int i = 0; i < friet_pkg::block_bytes; i++) begin
            mask[8*i +: 8] = (i < size_sat) ? 8'hff : 8'h00;
        end
    end

    // Domain bit depends on command kind
    always_comb begin
        if (direct) begin
            pad_bit = din_last;
        end else if (squeeze) begin
            pad_bit = 1'b0;
        end else begin
            pad_bit = ~din_last;
        end
    end

    // Pad pair right after the last data byte, spills into b on a full block
    assign pad = {{(pad_w-2){1'b0}}, 1'b1, pad_bit} << {size_sat, 3'b000};

    assign din_xor_a = din ^ a;

    // Decrypt overwrites the data bytes of a with the ciphertext
    assign inject_data = decrypt ? (din_xor_a & mask) : (din & mask);

    assign inj_a = inject_data ^ pad[lw-1:0];
    assign inj_b = {{(lw-2){1'b0}}, pad[pad_w-1:lw]};

    assign absorbed_state = {d ^ inj_a ^ inj_b, c, b ^ inj_b, a ^ inj_a};

    // Ciphertext on encrypt, plaintext on decrypt
    assign out_data = din_xor_a & mask;

endmodule

`default_nettype wire

//--- logic/friet_perm.sv
// Friet permutation engine: state and constant registers, unrolled rounds and parity check
`timescale 1ns/10ps
`default_nettype none

module friet_perm #(
    parameter int rounds_per_cycle = 2
) (
    input  logic              clk,
    input  logic              arstn,
    input  logic              permute,
    input  logic              clear,
    input  friet_pkg::state_t absorbed_state,
    output friet_pkg::state_t state,
    output logic              busy,
    output logic              fault_detected
);

    localparam int lw = friet_pkg::limb_w;
    localparam friet_pkg::rc_t last_rc = friet_pkg::end_rc(rounds_per_cycle);

    friet_pkg::state_t chain_state [0:rounds_per_cycle];
    friet_pkg::rc_t    chain_rc_c [0:rounds_per_cycle];
    friet_pkg::rc_t    chain_rc_d [0:rounds_per_cycle];
    friet_pkg::rc_t    rc_c_reg, rc_d_reg;
    friet_pkg::limb_t  parity;
    logic              state_defined;

    // A new command restarts the chain from the injected state
    assign chain_state[0] = permute ? absorbed_state : state;
    assign chain_rc_c[0] = permute ? friet_pkg::master_rc : rc_c_reg;
    assign chain_rc_d[0] = permute ? friet_pkg::master_rc : rc_d_reg;

    for (genvar i = 0; i < rounds_per_cycle; i++) begin : gen_rounds
        friet_round round_inst (
            .state    (chain_state[i]),
            .rc_c     (chain_rc_c[i]),
            .rc_d     (chain_rc_d[i]),
            .new_state(chain_state[i+1])
        );
        assign chain_rc_c[i+1] = friet_pkg::rc_step(chain_rc_c[i]);
        assign chain_rc_d[i+1] = friet_pkg::rc_step(chain_rc_d[i]);
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            state <= '0;
        end else if (permute || busy) begin
            state <= chain_state[rounds_per_cycle];
        end
    end

    assign parity = state[lw-1:0] ^ state[2*lw-1:lw] ^ state[3*lw-1:2*lw] ^ state[4*lw-1:3*lw];

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            busy <= 1'b0;
            rc_c_reg <= friet_pkg::master_rc;
            rc_d_reg <= friet_pkg::master_rc;
            fault_detected <= 1'b0;
            state_defined <= 1'b0;
        end else begin
            if (clear) begin
                busy <= 1'b0;
                fault_detected <= 1'b0;
                state_defined <= 1'b1;
            end else begin
                if (permute) begin
                    busy <= 1'b1;
                end else if (busy && rc_c_reg == last_rc) begin
                    busy <= 1'b0;
                end
                // Parity is only meaningful once init has defined the state
                if (state_defined && parity != '0) begin
                    fault_detected <= 1'b1;
                end
            end
            if (permute || busy) begin
                rc_c_reg <= chain_rc_c[rounds_per_cycle];
                rc_d_reg <= chain_rc_d[rounds_per_cycle];
            end
        end
    end

    // Control must hold off new commands until the permutation ends
    assert property (@(posedge clk) disable iff (!arstn) !(permute && busy));
    assert property (@(posedge clk) disable iff (!arstn) !(permute && clear));

endmodule

`default_nettype wire

//--- logic/friet_duplex_ctrl.sv
// Friet duplex control: command decode, input handshake and output register with back-pressure
`timescale 1ns/10ps
`default_nettype none

module friet_duplex_ctrl (
    input  logic             clk,
    input  logic             arstn,
    input  friet_pkg::oper_t oper,
    input  logic             din_valid,
    input  friet_pkg::size_t din_size,
    input  logic             din_last,
    input  logic             busy,
    input  friet_pkg::limb_t out_data,
    input  friet_pkg::limb_t limb_in,
    input  logic             dout_ready,
    output logic             din_ready,
    output logic             accept,
    output logic             permute,
    output logic             clear,
    output logic             decrypt,
    output logic             direct,
    output logic             squeeze,
    output friet_pkg::limb_t dout,
    output friet_pkg::size_t dout_size,
    output logic             dout_last,
    output logic             dout_valid
);

    logic is_perm;
    logic is_init;
    logic has_output;

    always_comb begin
        is_perm = 1'b0;
        is_init = 1'b0;
        has_output = 1'b0;
        case (oper)
            friet_pkg::oper_init: is_init = 1'b1;
            friet_pkg::oper_enc, friet_pkg::oper_dec, friet_pkg::oper_squeeze: begin
                is_perm = 1'b1;
                has_output = 1'b1;
            end
            friet_pkg::oper_direct, friet_pkg::oper_enc_silent,
            friet_pkg::oper_dec_silent: is_perm = 1'b1;
            // Reserved code is taken and dropped
            default: is_perm = 1'b0;
        endcase
    end

    assign decrypt = (oper == friet_pkg::oper_dec) || (oper == friet_pkg::oper_dec_silent);
    assign direct = (oper == friet_pkg::oper_direct);
    assign squeeze = (oper == friet_pkg::oper_squeeze);

    // Pending output lets input through only when it leaves this cycle
    assign din_ready = !busy && (!dout_valid || dout_ready);
    assign accept = din_valid && din_ready;
    assign permute = accept && is_perm;
    assign clear = accept && is_init;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            dout_valid <= 1'b0;
        end else if (accept && has_output) begin
            dout_valid <= 1'b1;
        end else if (dout_ready) begin
            dout_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && has_output) begin
            // Squeeze returns limb a as it stood before the command
            dout <= squeeze ? limb_in : out_data;
            dout_size <= squeeze ? friet_pkg::size_t'(friet_pkg::block_bytes) : din_size;
            dout_last <= din_last;
        end
    end

    assert property (@(posedge clk) disable iff (!arstn)
        dout_valid && !dout_ready |=> $stable(dout) && dout_valid);

endmodule

`default_nettype wire

//--- logic/friet_duplex.sv
// Friet duplex core top level: joins absorb, permutation and control
`timescale 1ns/10ps
`default_nettype none

module friet_duplex #(
    parameter int rounds_per_cycle = 2
) (
    input  logic             clk,
    input  logic             arstn,
    input  friet_pkg::oper_t oper,
    input  friet_pkg::limb_t din,
    input  friet_pkg::size_t din_size,
    input  logic             din_last,
    input  logic             din_valid,
    output logic             din_ready,
    output friet_pkg::limb_t dout,
    output friet_pkg::size_t dout_size,
    output logic             dout_last,
    output logic             dout_valid,
    input  logic             dout_ready,
    output logic             fault_detected
);

    friet_pkg::state_t state;
    friet_pkg::state_t absorbed_state;
    friet_pkg::limb_t  out_data;
    logic              accept, permute, clear;
    logic              decrypt, direct, squeeze;
    logic              busy;

    friet_absorb absorb_inst (
        .state         (state),
        .din           (din),
        .din_size      (din_size),
        .din_last      (din_last),
        .decrypt       (decrypt),
        .direct        (direct),
        .squeeze       (squeeze),
        .absorbed_state(absorbed_state),
        .out_data      (out_data)
    );

    friet_perm #(
        .rounds_per_cycle(rounds_per_cycle)
    ) perm_inst (
        .clk           (clk),
        .arstn         (arstn),
        .permute       (permute),
        .clear         (clear),
        .absorbed_state(absorbed_state),
        .state         (state),
        .busy          (busy),
        .fault_detected(fault_detected)
    );

    friet_duplex_ctrl ctrl_inst (
        .clk       (clk),
        .arstn     (arstn),
        .oper      (oper),
        .din_valid (din_valid),
        .din_size  (din_size),
        .din_last  (din_last),
        .busy      (busy),
        .out_data  (out_data),
        .limb_in   (state[friet_pkg::limb_w-1:0]),
        .dout_ready(dout_ready),
        .din_ready (din_ready),
        .accept    (accept),
        .permute   (permute),
        .clear     (clear),
        .decrypt   (decrypt),
        .direct    (direct),
        .squeeze   (squeeze),
        .dout      (dout),
        .dout_size (dout_size),
        .dout_last (dout_last),
        .dout_valid(dout_valid)
    );

    // Reserved commands are taken without any effect
    assert property (@(posedge clk) disable iff (!arstn)
        accept && oper == friet_pkg::oper_reserved |=> $stable(state) && $stable(dout));

endmodule

`default_nettype wire

//--- tb/friet_model.svh
// Friet duplex reference model: round, padding, block injection and command effects
`ifndef friet_model_svh
`define friet_model_svh

localparam int busy_cycles = 24 / rounds_per_cycle - 1;

friet_pkg::state_t m_state;
int m_busy;

function automatic friet_pkg::limb_t rotate_left(input friet_pkg::limb_t x, input int n);
    return (x << n) | (x >> (128 - n));
endfunction

// Shift left with feedback from bits 4 and 2
function automatic friet_pkg::rc_t advance_rc(input friet_pkg::rc_t rc);
    return {rc[3:0], rc[4] ^ rc[2]};
endfunction

function automatic friet_pkg::limb_t byte_mask(input friet_pkg::size_t size);
    friet_pkg::limb_t m;
    m = '0;
    for (int i = 0; i < 16; i++) begin
        if (i < int'(size)) begin
            m[8*i +: 8] = 8'hff;
        end
    end
    return m;
endfunction

function automatic friet_pkg::state_t round_function(input friet_pkg::state_t s,
        input friet_pkg::rc_t rc_c, input friet_pkg::rc_t rc_d);
    friet_pkg::limb_t a, b, c, d;
    friet_pkg::limb_t na, nb, nc, mix, nl;
    {d, c, b, a} = s;
    c = c ^ {123'b0, rc_c};
    b = b ^ {123'b0, rc_d};
    d = d ^ {123'b0, rc_c} ^ {123'b0, rc_d};
    // Limbs move (a, b, c) to (c, a, b)
    na = c;
    nb = a;
    nc = b;
    mix = rotate_left(nb, friet_pkg::rot_mix);
    nc = nc ^ mix;
    nl = rotate_left(nb, friet_pkg::rot_and_b) & rotate_left(nc, friet_pkg::rot_and_c);
    na = na ^ nl;
    d = d ^ mix ^ nl;
    return {d, nc, nb, na};
endfunction

function automatic friet_pkg::state_t full_permutation(input friet_pkg::state_t s);
    friet_pkg::rc_t rc;
    rc = 5'b01111;
    for (int r = 0; r < 24; r++) begin
        s = round_function(s, rc, rc);
        rc = advance_rc(rc);
    end
    return s;
endfunction

task automatic update_model(input friet_pkg::oper_t op, input friet_pkg::limb_t data,
        input friet_pkg::size_t size, input logic last);
    friet_pkg::limb_t a, b, c, d, mask, out, inj_a, inj_b;
    logic [129:0] pad;
    logic pad_bit;
    logic is_dec;
    int nbytes;
    {d, c, b, a} = m_state;
    mask = byte_mask(size);
    out = (data ^ a) & mask;
    nbytes = (int'(size) > 16) ? 16 : int'(size);
    is_dec = (op == friet_pkg::oper_dec) || (op == friet_pkg::oper_dec_silent);
    if (op == friet_pkg::oper_direct) begin
        pad_bit = last;
    end else if (op == friet_pkg::oper_squeeze) begin
        pad_bit = 1'b0;
    end else begin
        pad_bit = !last;
    end
    // Full block pushes the pad pair into the low bits of b
    pad = {128'b0, 1'b1, pad_bit} << (8 * nbytes);
    inj_a = pad[127:0] ^ (is_dec ? out : (data & mask));
    inj_b = {126'b0, pad[129:128]};
    case (op)
        friet_pkg::oper_init: m_state = '0;
        friet_pkg::oper_reserved: begin
        end
        default: begin
            m_state = full_permutation({d ^ inj_a ^ inj_b, c, b ^ inj_b, a ^ inj_a});
            m_busy = busy_cycles;
        end
    endcase
    if (op == friet_pkg::oper_enc || op == friet_pkg::oper_dec) begin
        exp_data.push_back(out);
        exp_size.push_back(size);
        exp_last.push_back(last);
    end else if (op == friet_pkg::oper_squeeze) begin
        exp_data.push_back(a);
        exp_size.push_back(5'd16);
        exp_last.push_back(last);
    end
endtask

`endif

//--- tb/friet_duplex_tb.sv
// Friet duplex testbench: directed and random commands checked against a reference model
`timescale 1ns/10ps
`default_nettype none

module friet_duplex_tb;

    localparam int rounds_per_cycle = 2;
    localparam int clk_period = 100;
    localparam int wait_limit = 200;

    logic clk;
    logic arstn;
    friet_pkg::oper_t oper;
    friet_pkg::limb_t din;
    friet_pkg::size_t din_size;
    logic din_last;
    logic din_valid;
    logic din_ready;
    friet_pkg::limb_t dout;
    friet_pkg::size_t dout_size;
    logic dout_last;
    logic dout_valid;
    logic dout_ready;
    logic fault_detected;

    // Expected outputs in order
    friet_pkg::limb_t exp_data[$];
    friet_pkg::size_t exp_size[$];
    logic exp_last[$];

    logic [31:0] rng;
    int errors;
    int commands;
    int outputs;
    logic accepted;
    logic hold_low;
    logic stalled;
    friet_pkg::limb_t stall_dout;

    `include "friet_model.svh"

    friet_duplex #(
        .rounds_per_cycle(rounds_per_cycle)
    ) friet_duplex_inst (
        .clk           (clk),
        .arstn         (arstn),
        .oper          (oper),
        .din           (din),
        .din_size      (din_size),
        .din_last      (din_last),
        .din_valid     (din_valid),
        .din_ready     (din_ready),
        .dout          (dout),
        .dout_size     (dout_size),
        .dout_last     (dout_last),
        .dout_valid    (dout_valid),
        .dout_ready    (dout_ready),
        .fault_detected(fault_detected)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic friet_pkg::limb_t random_block();
        friet_pkg::limb_t v;
        for (int i = 0; i < 4; i++) begin
            v[32*i +: 32] = next_rand();
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input friet_pkg::limb_t expected,
            input friet_pkg::limb_t actual);
        errors++;
        $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Errors: %0d, commands: %0d, outputs: %0d", errors, commands, outputs);
        $display("ERRORS FOUND");
        $finish;
    endtask

    // Runs just before the rising edge where all inputs and registers are settled
    task automatic sample_and_check();
        logic exp_ready;
        exp_ready = (m_busy == 0) && (exp_data.size() == 0 || dout_ready);
        assert (din_ready == exp_ready)
            else report_mismatch("din_ready", 128'(exp_ready), 128'(din_ready));
        assert (dout_valid == (exp_data.size() != 0))
            else report_mismatch("dout_valid", 128'(exp_data.size() != 0), 128'(dout_valid));
        assert (fault_detected == 1'b0)
            else report_mismatch("fault_detected", 128'(0), 128'(fault_detected));
        if (stalled) begin
            assert (dout == stall_dout) else report_mismatch("dout held", stall_dout, dout);
        end
        if (dout_valid && dout_ready && exp_data.size() != 0) begin
            assert (dout == exp_data[0]) else report_mismatch("dout", exp_data[0], dout);
            assert (dout_size == exp_size[0])
                else report_mismatch("dout_size", 128'(exp_size[0]), 128'(dout_size));
            assert (dout_last == exp_last[0])
                else report_mismatch("dout_last", 128'(exp_last[0]), 128'(dout_last));
            void'(exp_data.pop_front());
            void'(exp_size.pop_front());
            void'(exp_last.pop_front());
            outputs++;
        end
        stalled = dout_valid && !dout_ready;
        stall_dout = dout;
        if (m_busy > 0) begin
            m_busy--;
        end
        if (din_valid && din_ready) begin
            update_model(oper, din, din_size, din_last);
            accepted = 1'b1;
            commands++;
        end
    endtask

    // One clock cycle from falling edge to falling edge
    task automatic tick();
        #(clk_period / 2 - 10);
        sample_and_check();
        @(negedge clk);
        if (accepted) begin
            din_valid = 1'b0;
        end
        dout_ready = hold_low ? 1'b0 : (next_rand() % 4 != 0);
    endtask

    task automatic drive(input friet_pkg::oper_t op, input friet_pkg::limb_t data,
            input friet_pkg::size_t size, input logic last);
        oper = op;
        din = data;
        din_size = size;
        din_last = last;
        din_valid = 1'b1;
        accepted = 1'b0;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        while (!accepted) begin
            tick();
            n++;
            if (!accepted && n >= wait_limit) begin
                stop_on_timeout("command was not accepted in time");
            end
        end
    endtask

    // Lets every queued output leave and the permutation finish
    task automatic drain_outputs();
        int n;
        n = 0;
        while (exp_data.size() != 0 || m_busy != 0) begin
            tick();
            n++;
            if ((exp_data.size() != 0 || m_busy != 0) && n >= wait_limit) begin
                stop_on_timeout("pending output was never delivered");
            end
        end
    endtask

    task automatic issue(input friet_pkg::oper_t op, input friet_pkg::limb_t data,
            input friet_pkg::size_t size, input logic last);
        repeat (next_rand() % 3) tick();
        drive(op, data, size, last);
        wait_accept();
    endtask

    initial begin
        friet_pkg::limb_t pt[4];
        friet_pkg::limb_t ct[4];
        friet_pkg::size_t sz[4];
        friet_pkg::oper_t op;
        clk = 1'b0;
        arstn = 1'b0;
        oper = friet_pkg::oper_init;
        din = '0;
        din_size = '0;
        din_last = 1'b0;
        din_valid = 1'b0;
        dout_ready = 1'b1;
        rng = 32'd7;
        errors = 0;
        commands = 0;
        outputs = 0;
        accepted = 1'b0;
        hold_low = 1'b0;
        stalled = 1'b0;
        stall_dout = '0;
        m_state = '0;
        m_busy = 0;

        repeat (16) @(negedge clk);
        arstn = 1'b1;
        // Idle outputs after reset are checked on every tick
        tick();

        // Limb a is zero right after init
        issue(friet_pkg::oper_init, random_block(), 5'd0, 1'b0);
        issue(friet_pkg::oper_squeeze, random_block(), 5'd0, 1'b0);

        // Encrypt a short message and decrypt it again from a fresh state
        issue(friet_pkg::oper_init, '0, 5'd0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            pt[i] = random_block();
            sz[i] = friet_pkg::size_t'(next_rand() % 17);
            issue(friet_pkg::oper_enc, pt[i], sz[i], i == 3);
            ct[i] = exp_data[$];
        end
        issue(friet_pkg::oper_init, '0, 5'd0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            issue(friet_pkg::oper_dec, ct[i], sz[i], i == 3);
            assert (exp_data[$] == (pt[i] & byte_mask(sz[i])))
                else report_mismatch("decrypted block", pt[i] & byte_mask(sz[i]), exp_data[$]);
        end

        // Silent absorbs at every size with a squeeze after each
        issue(friet_pkg::oper_init, '0, 5'd0, 1'b0);
        for (int s = 0; s <= 16; s++) begin
            if (s % 3 == 0) begin
                op = friet_pkg::oper_direct;
            end else if (s % 3 == 1) begin
                op = friet_pkg::oper_enc_silent;
            end else begin
                op = friet_pkg::oper_dec_silent;
            end
            issue(op, random_block(), friet_pkg::size_t'(s), next_rand() % 2 == 1);
            issue(friet_pkg::oper_squeeze, random_block(), 5'd0, 1'b0);
        end

        // Stalled sink keeps the output and blocks the next command
        drain_outputs();
        hold_low = 1'b1;
        issue(friet_pkg::oper_enc, random_block(), 5'd16, 1'b0);
        drive(friet_pkg::oper_squeeze, random_block(), 5'd0, 1'b1);
        repeat (20) tick();
        hold_low = 1'b0;
        wait_accept();

        for (int k = 0; k < 300; k++) begin
            op = friet_pkg::oper_t'(next_rand() % 8);
            issue(op, random_block(), friet_pkg::size_t'(next_rand() % 17),
                  next_rand() % 2 == 1);
        end

        drain_outputs();

        $display("Errors: %0d, commands: %0d, outputs: %0d", errors, commands, outputs);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- friet_duplex.f
+incdir+tb
logic/friet_pkg.sv
logic/friet_round.sv
logic/friet_absorb.sv
logic/friet_perm.sv
logic/friet_duplex_ctrl.sv
logic/friet_duplex.sv
tb/friet_duplex_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module friet_duplex_tb \
    -f friet_duplex.f -o friet_duplex_sim

./obj_dir/friet_duplex_sim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
